// ==== design/fencei_cfg_regs.sv ====
/* Configuration and status registers: bufferable store enable
   and the retired fence.i counter */
`default_nettype none

module fencei_cfg_regs (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            cfg_we_i,
  input  logic [fencei_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [fencei_pkg::XLEN-1:0]     cfg_wdata_i,
  output logic [fencei_pkg::XLEN-1:0]     cfg_rdata_o,
  input  logic                            fence_retired_i,
  output logic                            bufferable_en_o
);
  import fencei_pkg::*;

  logic            bufferable_en_q;
  logic [XLEN-1:0] fence_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bufferable_en_q <= 1'b0;
      fence_cnt_q     <= '0;
    end else begin
      if (cfg_we_i && cfg_addr_i == CFG_ADDR_CTRL) begin
        bufferable_en_q <= cfg_wdata_i[0];
      end
      // Software clear wins over a retire in the same cycle
      if (cfg_we_i && cfg_addr_i == CFG_ADDR_FENCE_CNT) begin
        fence_cnt_q <= '0;
      end else if (fence_retired_i) begin
        fence_cnt_q <= fence_cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg_addr_i)
      CFG_ADDR_CTRL:      cfg_rdata_o = {{(XLEN-1){1'b0}}, bufferable_en_q};
      CFG_ADDR_FENCE_CNT: cfg_rdata_o = fence_cnt_q;
      default:            cfg_rdata_o = '0;
    endcase
  end

  assign bufferable_en_o = bufferable_en_q;

  // A retire is a single-cycle event from the controller FSM
  a_retire_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fence_retired_i |=> !fence_retired_i);

endmodule : fencei_cfg_regs

`default_nettype wire

// ==== design/fencei_ctrl.sv ====
/* fence.i sequencing FSM: drain, flush handshake, retire and refetch,
   with protocol assertions on the flush request */
`default_nettype none

module fencei_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        wb_fencei_i,
  input  logic [fencei_pkg::XLEN-1:0] wb_pc_i,
  input  fencei_pkg::wbuf_state_e     buf_state_i,
  input  logic                        outstanding_zero_i,
  input  logic                        data_req_i,
  output logic                        drain_hold_o,
  output logic                        fencei_flush_req_o,
  input  logic                        fencei_flush_ack_i,
  output logic                        wb_retire_o,
  output logic                        fence_retired_o,
  output logic                        instr_req_o,
  output logic [fencei_pkg::XLEN-1:0] instr_addr_o,
  input  logic                        instr_gnt_i
);
  import fencei_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    DRAIN,
    FLUSH,
    RETIRE_FETCH,
    DONE
  } state_e;

  state_e          state_q;
  state_e          state_d;
  logic            drained;
  logic            flush_done;
  logic            fetch_pend_q;
  logic [XLEN-1:0] instr_addr_q;

  // Empty slot means no request, so the count cannot rise next cycle
  assign drained    = (buf_state_i == WBUF_EMPTY) && outstanding_zero_i;
  assign flush_done = (state_q == FLUSH) && fencei_flush_ack_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (wb_fencei_i) begin
          state_d = drained ? FLUSH : DRAIN;
        end
      end
      DRAIN: begin
        if (drained) begin
          state_d = FLUSH;
        end
      end
      FLUSH: begin
        if (fencei_flush_ack_i) begin
          state_d = RETIRE_FETCH;
        end
      end
      RETIRE_FETCH: state_d = DONE;
      // Wait for the fetch grant and for writeback to drop the fence
      DONE: begin
        if (!wb_fencei_i && !fetch_pend_q) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      fetch_pend_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (flush_done) begin
        fetch_pend_q <= 1'b1;
      end else if (fetch_pend_q && instr_gnt_i) begin
        fetch_pend_q <= 1'b0;
      end
    end
  end

  // Next word after the fence.i, sampled while the pc is held
  always_ff @(posedge clk_i) begin
    if (flush_done) begin
      instr_addr_q <= {wb_pc_i[XLEN-1:2], 2'b00} + XLEN'(4);
    end
  end

  assign drain_hold_o       = (state_q != IDLE) || wb_fencei_i;
  assign fencei_flush_req_o = (state_q == FLUSH);
  assign wb_retire_o        = (state_q == RETIRE_FETCH);
  assign fence_retired_o    = (state_q == RETIRE_FETCH);
  assign instr_req_o        = fetch_pend_q;
  assign instr_addr_o       = instr_addr_q;

  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fencei_flush_req_o && !fencei_flush_ack_i |=> fencei_flush_req_o);

  a_req_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fencei_flush_req_o && fencei_flush_ack_i |=> !fencei_flush_req_o);

  a_no_data_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fencei_flush_req_o |-> !data_req_i);

  a_req_drained: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fencei_flush_req_o |-> outstanding_zero_i && (buf_state_i == WBUF_EMPTY));

  // Writeback must hold the fence.i pc until the ack
  a_pc_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fencei_flush_req_o && !fencei_flush_ack_i |=> $stable(wb_pc_i));

endmodule : fencei_ctrl

`default_nettype wire

// ==== design/fencei_pkg.sv ====
/* Shared definitions for the fence.i unit: write-buffer state,
   data widths and configuration register offsets */
`default_nettype none

package fencei_pkg;

  // Address and data width of both buses
  localparam int unsigned XLEN = 32;

  // Configuration register space
  localparam int unsigned CFG_ADDR_W = 2;

  // Control register, bit 0 enables bufferable stores
  localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_CTRL = CFG_ADDR_W'(0);
  // Retired fence.i count, a write clears it
  localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_FENCE_CNT = CFG_ADDR_W'(1);

  // Occupancy of the single store slot
  typedef enum logic {
    WBUF_EMPTY = 1'b0,
    WBUF_FULL  = 1'b1
  } wbuf_state_e;

endpackage : fencei_pkg

`default_nettype wire

// ==== design/fencei_unit.sv ====
/* Top level of the fence.i unit: registers, store buffer,
   outstanding counter and sequencing FSM */
`default_nettype none

module fencei_unit #(
  parameter int unsigned MAX_OUTSTANDING = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Writeback
  input  logic                              wb_fencei_i,
  input  logic [fencei_pkg::XLEN-1:0]       wb_pc_i,
  output logic                              wb_retire_o,
  // Store input
  input  logic                              st_valid_i,
  input  logic [fencei_pkg::XLEN-1:0]       st_addr_i,
  input  logic [fencei_pkg::XLEN-1:0]       st_wdata_i,
  output logic                              st_accept_o,
  // OBI data bus
  output logic                              data_req_o,
  output logic [fencei_pkg::XLEN-1:0]       data_addr_o,
  output logic [fencei_pkg::XLEN-1:0]       data_wdata_o,
  input  logic                              data_gnt_i,
  input  logic                              data_rvalid_i,
  // Instruction side flush handshake
  output logic                              fencei_flush_req_o,
  input  logic                              fencei_flush_ack_i,
  // Refetch
  output logic                              instr_req_o,
  output logic [fencei_pkg::XLEN-1:0]       instr_addr_o,
  input  logic                              instr_gnt_i,
  // Configuration
  input  logic                              cfg_we_i,
  input  logic [fencei_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [fencei_pkg::XLEN-1:0]       cfg_wdata_i,
  output logic [fencei_pkg::XLEN-1:0]       cfg_rdata_o
);
  import fencei_pkg::*;

  wbuf_state_e buf_state;
  logic        bufferable_en;
  logic        drain_hold;
  logic        outstanding_zero;
  logic        outstanding_full;
  logic        fence_retired;

  fencei_cfg_regs i_cfg_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cfg_we_i        (cfg_we_i),
    .cfg_addr_i      (cfg_addr_i),
    .cfg_wdata_i     (cfg_wdata_i),
    .cfg_rdata_o     (cfg_rdata_o),
    .fence_retired_i (fence_retired),
    .bufferable_en_o (bufferable_en)
  );

  obi_outstanding_counter #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_outstanding_counter (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .data_req_i         (data_req_o),
    .data_gnt_i         (data_gnt_i),
    .data_rvalid_i      (data_rvalid_i),
    .outstanding_zero_o (outstanding_zero),
    .outstanding_full_o (outstanding_full)
  );

  store_write_buffer #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_write_buffer (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .st_valid_i         (st_valid_i),
    .st_addr_i          (st_addr_i),
    .st_wdata_i         (st_wdata_i),
    .st_accept_o        (st_accept_o),
    .bufferable_en_i    (bufferable_en),
    .drain_hold_i       (drain_hold),
    .outstanding_zero_i (outstanding_zero),
    .outstanding_full_i (outstanding_full),
    .buf_state_o        (buf_state),
    .data_req_o         (data_req_o),
    .data_addr_o        (data_addr_o),
    .data_wdata_o       (data_wdata_o),
    .data_gnt_i         (data_gnt_i)
  );

  fencei_ctrl i_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .wb_fencei_i        (wb_fencei_i),
    .wb_pc_i            (wb_pc_i),
    .buf_state_i        (buf_state),
    .outstanding_zero_i (outstanding_zero),
    .data_req_i         (data_req_o),
    .drain_hold_o       (drain_hold),
    .fencei_flush_req_o (fencei_flush_req_o),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .wb_retire_o        (wb_retire_o),
    .fence_retired_o    (fence_retired),
    .instr_req_o        (instr_req_o),
    .instr_addr_o       (instr_addr_o),
    .instr_gnt_i        (instr_gnt_i)
  );

endmodule : fencei_unit

`default_nettype wire

// ==== design/obi_outstanding_counter.sv ====
/* Outstanding data-bus transaction counter, granted but not yet answered */
`default_nettype none

module obi_outstanding_counter #(
  parameter int unsigned MAX_OUTSTANDING = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic data_req_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic outstanding_zero_o,
  output logic outstanding_full_o
);

  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             granted;

  assign granted = data_req_i && data_gnt_i;

  // A grant and a response in the same cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (granted && !data_rvalid_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (data_rvalid_i && !granted) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign outstanding_zero_o = (cnt_q == '0);
  assign outstanding_full_o = (cnt_q == CNT_W'(MAX_OUTSTANDING));

  // Every response must belong to an earlier grant
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i |-> !outstanding_zero_o);

  // Issue is withheld by the buffer once the counter is full
  a_no_gnt_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    granted |-> !outstanding_full_o);

endmodule : obi_outstanding_counter

`default_nettype wire

// ==== design/store_write_buffer.sv ====
/* One-entry store buffer that issues buffered writes on the OBI data bus */
`default_nettype none

module store_write_buffer #(
  parameter int unsigned MAX_OUTSTANDING = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          st_valid_i,
  input  logic [fencei_pkg::XLEN-1:0]   st_addr_i,
  input  logic [fencei_pkg::XLEN-1:0]   st_wdata_i,
  output logic                          st_accept_o,
  input  logic                          bufferable_en_i,
  input  logic                          drain_hold_i,
  input  logic                          outstanding_zero_i,
  input  logic                          outstanding_full_i,
  output fencei_pkg::wbuf_state_e       buf_state_o,
  output logic                          data_req_o,
  output logic [fencei_pkg::XLEN-1:0]   data_addr_o,
  output logic [fencei_pkg::XLEN-1:0]   data_wdata_o,
  input  logic                          data_gnt_i
);
  import fencei_pkg::*;

  wbuf_state_e     state_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] wdata_q;
  logic            st_take;

  // Non-bufferable stores wait until the bus has gone quiet.
  // Holding stores during a fence keeps anything new off the bus
  assign st_accept_o = (state_q == WBUF_EMPTY) && !drain_hold_i &&
                       (bufferable_en_i || outstanding_zero_i);
  assign st_take     = st_valid_i && st_accept_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WBUF_EMPTY;
    end else if (st_take) begin
      state_q <= WBUF_FULL;
    end else if (data_req_o && data_gnt_i) begin
      state_q <= WBUF_EMPTY;
    end
  end

  always_ff @(posedge clk_i) begin
    if (st_take) begin
      addr_q  <= st_addr_i;
      wdata_q <= st_wdata_i;
    end
  end

  // Counter only grows on our own grants, so the request cannot drop
  // once raised
  assign data_req_o   = (state_q == WBUF_FULL) && !outstanding_full_i;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;
  assign buf_state_o  = state_q;

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=>
      data_req_o && $stable(data_addr_o) && $stable(data_wdata_o));

  // At most one grant per cycle, so filling the counter takes the full depth
  if (MAX_OUTSTANDING > 1) begin : gen_fill_bound
    a_fill_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
      outstanding_full_i |-> !$past(outstanding_zero_i, MAX_OUTSTANDING - 1));
  end

endmodule : store_write_buffer

`default_nettype wire

// ==== project.f ====
design/fencei_pkg.sv
design/fencei_cfg_regs.sv
design/obi_outstanding_counter.sv
design/store_write_buffer.sv
design/fencei_ctrl.sv
design/fencei_unit.sv
testbench/tb_fencei_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fence.i unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f project.f --top-module tb_fencei_unit \
  --Mdir "$BUILD_DIR" -o sim_fencei
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_fencei" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== testbench/tb_fencei_unit.sv ====
/* Random-stimulus testbench for the fence.i unit: OBI bus responder,
   store and outstanding-count reference model, flush and refetch checks */
`default_nettype none

module tb_fencei_unit;
  import fencei_pkg::*;

  localparam int unsigned MAX_OUTSTANDING = 4;
  localparam int TIMEOUT = 500;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic wb_fencei_i;
  logic [XLEN-1:0] wb_pc_i;
  logic wb_retire_o;
  logic st_valid_i;
  logic [XLEN-1:0] st_addr_i;
  logic [XLEN-1:0] st_wdata_i;
  logic st_accept_o;
  logic data_req_o;
  logic [XLEN-1:0] data_addr_o;
  logic [XLEN-1:0] data_wdata_o;
  logic data_gnt_i;
  logic data_rvalid_i;
  logic fencei_flush_req_o;
  logic fencei_flush_ack_i;
  logic instr_req_o;
  logic [XLEN-1:0] instr_addr_o;
  logic instr_gnt_i;
  logic cfg_we_i;
  logic [CFG_ADDR_W-1:0] cfg_addr_i;
  logic [XLEN-1:0] cfg_wdata_i;
  logic [XLEN-1:0] cfg_rdata_o;

  // Reference model, updated on every rising edge
  logic [63:0] store_q[$];
  int model_out = 0;
  bit model_buf = 1'b0;
  logic [XLEN-1:0] model_cnt = '0;
  int retires = 0;
  bit fetch_wait = 1'b0;
  logic [XLEN-1:0] fetch_exp = '0;
  bit prev_req = 1'b0;
  bit prev_ack = 1'b0;
  // High from the fence.i raise until refetch is done and writeback has let go
  bit fence_busy = 1'b0;

  // Responder state, one response slot per granted write
  int cycle = 0;
  int resp_due[$];
  int ack_wait = 0;
  bit ack_armed = 1'b0;

  fencei_unit #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) i_fencei_unit (.*);

  always #5 clk_i = ~clk_i;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check(input string name, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Data grants, in-order responses, flush ack and fetch grant
  task automatic respond_bus();
    int due;
    cycle++;
    data_rvalid_i = 1'b0;
    if (resp_due.size() > 0 && resp_due[0] <= cycle) begin
      data_rvalid_i = 1'b1;
      void'(resp_due.pop_front());
    end
    data_gnt_i = data_req_o && ($urandom_range(0, 2) == 0);
    if (data_gnt_i) begin
      due = cycle + $urandom_range(1, 4);
      resp_due.push_back(due);
    end
    fencei_flush_ack_i = 1'b0;
    if (!fencei_flush_req_o) begin
      ack_armed = 1'b0;
    end else begin
      if (!ack_armed) begin
        ack_wait = $urandom_range(0, 5);
        ack_armed = 1'b1;
      end
      if (ack_wait == 0) begin
        fencei_flush_ack_i = 1'b1;
      end else begin
        ack_wait--;
      end
    end
    instr_gnt_i = instr_req_o && ($urandom_range(0, 3) == 0);
  endtask

  task automatic tick();
    @(posedge clk_i);
    @(negedge clk_i);
    respond_bus();
  endtask

  task automatic drive_store();
    st_valid_i = ($urandom_range(0, 1) == 1);
    st_addr_i  = $urandom() & 32'hffff_fffc;
    st_wdata_i = $urandom();
  endtask

  task automatic read_cfg(input logic [CFG_ADDR_W-1:0] addr, output logic [XLEN-1:0] data);
    cfg_addr_i = addr;
    @(posedge clk_i);
    data = cfg_rdata_o;
    @(negedge clk_i);
    respond_bus();
  endtask

  task automatic write_cfg(input logic [CFG_ADDR_W-1:0] addr, input logic [XLEN-1:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    tick();
    cfg_we_i = 1'b0;
  endtask

  // One fence.i from raise to refetch grant, stores keep arriving meanwhile
  task automatic run_fence();
    int start;
    int n;
    start = retires;
    wb_fencei_i = 1'b1;
    wb_pc_i = $urandom();
    for (n = 0; n < TIMEOUT && retires == start; n++) begin
      drive_store();
      tick();
    end
    if (retires == start) begin
      fail_run("timeout waiting for the fence.i to retire");
    end
    wb_fencei_i = 1'b0;
    st_valid_i = 1'b0;
    for (n = 0; n < TIMEOUT && fetch_wait; n++) begin
      tick();
    end
    if (fetch_wait) begin
      fail_run("timeout waiting for the refetch grant");
    end
    tick();
  endtask

  task automatic run_traffic(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      if ($urandom_range(0, 39) == 0) begin
        run_fence();
      end else begin
        drive_store();
        tick();
      end
    end
    st_valid_i = 1'b0;
    run_fence();
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // Acceptance depends on the slot, the fence.i window and the store policy
      check("st_accept_o", XLEN'(st_accept_o),
            XLEN'(store_q.size() == 0 && !wb_fencei_i && !fence_busy &&
                  (model_buf || model_out == 0)));
      if (wb_fencei_i) begin
        fence_busy = 1'b1;
      end else if (!fetch_wait) begin
        fence_busy = 1'b0;
      end
      if (fencei_flush_req_o) begin
        check("outstanding count at fencei_flush_req_o", model_out, 0);
        check("ungranted stores at fencei_flush_req_o", store_q.size(), 0);
        check("data_req_o during fencei_flush_req_o", XLEN'(data_req_o), 0);
      end
      if (prev_req && !prev_ack) begin
        check("fencei_flush_req_o before ack", XLEN'(fencei_flush_req_o), 1);
      end
      if (prev_req && prev_ack) begin
        check("fencei_flush_req_o after ack", XLEN'(fencei_flush_req_o), 0);
      end
      check("wb_retire_o", XLEN'(wb_retire_o), XLEN'(prev_req && prev_ack));
      if (wb_retire_o) begin
        check("instr_req_o at wb_retire_o", XLEN'(instr_req_o), 1);
        retires++;
        fetch_wait = 1'b1;
        fetch_exp = (wb_pc_i & ~32'h3) + 32'd4;
      end
      if (fetch_wait && instr_req_o && instr_gnt_i) begin
        check("instr_addr_o", instr_addr_o, fetch_exp);
        fetch_wait = 1'b0;
      end
      // Counts before this edge decide acceptance
      if (st_valid_i && st_accept_o) begin
        if (!model_buf) begin
          check("outstanding count at non-bufferable store", model_out, 0);
        end
        store_q.push_back({st_addr_i, st_wdata_i});
      end
      if (data_req_o && data_gnt_i) begin
        if (store_q.size() == 0) begin
          fail_run("data bus grant with no accepted store pending");
        end else begin
          check("data_addr_o", data_addr_o, store_q[0][63:32]);
          check("data_wdata_o", data_wdata_o, store_q[0][31:0]);
          void'(store_q.pop_front());
          model_out++;
        end
      end
      if (data_rvalid_i) begin
        model_out--;
      end
      if (cfg_we_i && cfg_addr_i == CFG_ADDR_CTRL) begin
        model_buf = cfg_wdata_i[0];
      end
      if (cfg_we_i && cfg_addr_i == CFG_ADDR_FENCE_CNT) begin
        model_cnt = '0;
      end else if (wb_retire_o) begin
        model_cnt++;
      end
      prev_req = fencei_flush_req_o;
      prev_ack = fencei_flush_ack_i;
    end
  end

  initial begin
    logic [XLEN-1:0] rdata;
    void'($urandom(32'hf600af85));
    rst_ni = 1'b0;
    wb_fencei_i = 1'b0;
    wb_pc_i = '0;
    st_valid_i = 1'b0;
    st_addr_i = '0;
    st_wdata_i = '0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    fencei_flush_ack_i = 1'b0;
    instr_gnt_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    check("data_req_o after reset", XLEN'(data_req_o), 0);
    check("fencei_flush_req_o after reset", XLEN'(fencei_flush_req_o), 0);
    check("wb_retire_o after reset", XLEN'(wb_retire_o), 0);
    check("instr_req_o after reset", XLEN'(instr_req_o), 0);
    @(negedge clk_i);
    respond_bus();
    read_cfg(CFG_ADDR_CTRL, rdata);
    check("cfg_rdata_o ctrl after reset", rdata, 0);
    read_cfg(CFG_ADDR_FENCE_CNT, rdata);
    check("cfg_rdata_o fence count after reset", rdata, 0);

    // Non-bufferable stores first, then bufferable
    run_traffic(300);
    read_cfg(CFG_ADDR_FENCE_CNT, rdata);
    check("cfg_rdata_o fence count", rdata, model_cnt);
    write_cfg(CFG_ADDR_CTRL, 32'd1);
    read_cfg(CFG_ADDR_CTRL, rdata);
    check("cfg_rdata_o ctrl", rdata, 1);
    run_traffic(300);
    read_cfg(CFG_ADDR_FENCE_CNT, rdata);
    check("cfg_rdata_o fence count", rdata, model_cnt);
    // Any write clears the count, whatever the data
    write_cfg(CFG_ADDR_FENCE_CNT, 32'hffff_ffff);
    read_cfg(CFG_ADDR_FENCE_CNT, rdata);
    check("cfg_rdata_o fence count after clear", rdata, 0);
    check("outstanding count at end", model_out, 0);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule : tb_fencei_unit

`default_nettype wire
